// ==== tb.f ====
common/cpu_pkg.sv
design/fetch_unit.sv
design/detect_jump.sv
design/decode_stage.sv
design/reg_file.sv
design/execute_stage.sv
design/cpu_top.sv
tests/cpu_props.sv
tests/cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cpu testbench with Verilator, then check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f --top-module cpu_tb -o cpu_tb_sim

./obj_dir/cpu_tb_sim +verilator+error+limit+1000 | tee sim.log

if grep -qx "TEST OK" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// ==== tests/cpu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;

  localparam int PERIOD_NS = 40;
  localparam int RESET_CYCLES = 3;
  localparam int WINDOW = 2000;
  localparam int NTESTS = 6;
  localparam int MAX_STEPS = 4096;
  localparam int WATCHDOG_NS = NTESTS * (WINDOW + RESET_CYCLES + 2) * PERIOD_NS + 20 * PERIOD_NS;
  localparam logic [31:0] SEED = 32'hccd06b21;

  // the lower half of the selector picks one of the plain ALU operations
  localparam cpu_pkg::opcode_t ALU_OPS [8] = '{
    cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_CMP, cpu_pkg::OP_AND,
    cpu_pkg::OP_OR, cpu_pkg::OP_ADDI, cpu_pkg::OP_SUBI, cpu_pkg::OP_LI
  };

  // the upper half picks from a set that gives each test its flavour
  localparam cpu_pkg::opcode_t SPECIAL_OPS [NTESTS][4] = '{
    '{cpu_pkg::OP_CMPI, cpu_pkg::OP_LI, 5'b00000, 5'b00111},
    '{cpu_pkg::OP_J, cpu_pkg::OP_CALL, cpu_pkg::OP_CALL, cpu_pkg::OP_LI},
    '{cpu_pkg::OP_JZ, cpu_pkg::OP_JN, cpu_pkg::OP_CMPI, cpu_pkg::OP_CMP},
    '{cpu_pkg::OP_JR, cpu_pkg::OP_JZR, cpu_pkg::OP_JNR, cpu_pkg::OP_CALLR},
    '{cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_ADDI, cpu_pkg::OP_OR},
    '{cpu_pkg::OP_J, cpu_pkg::OP_JZ, cpu_pkg::OP_JNR, cpu_pkg::OP_CALLR}
  };

  logic                      clk;
  logic                      arst_n;
  logic [cpu_pkg::PC_W-1:0]  imem_addr;
  cpu_pkg::instr_t           imem_data;
  cpu_pkg::wb_t              wb;

  cpu_pkg::instr_t  mem [2048];
  logic [31:0]      lfsr;
  int               errors;
  int               total_writes;

  // architectural state of the reference model
  logic [15:0]  m_regs [8];
  logic         m_z;
  logic         m_n;
  logic [10:0]  m_pc;

  cpu_top dut_i (
    .i_clk       (clk),
    .i_arst_n    (arst_n),
    .o_imem_addr (imem_addr),
    .i_imem_data (imem_data),
    .o_wb        (wb)
  );

  always #(PERIOD_NS / 2) clk = ~clk;

  // taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic cpu_pkg::instr_t random_word(input int t);
    logic [3:0]        sel;
    logic [10:0]       upper;
    cpu_pkg::opcode_t  opc;
    sel = 4'(rand_bits(4));
    upper = 11'(rand_bits(11));
    opc = sel[3] ? SPECIAL_OPS[3'(t)][sel[1:0]] : ALU_OPS[sel[2:0]];
    // the dependency test keeps every register field on r0 or r1
    if (t == 4) begin
      upper[2:1] = 2'b00;
      upper[5:4] = 2'b00;
      upper[8:7] = 2'b00;
    end
    return {upper, opc};
  endfunction

  function automatic string test_name(input int t);
    case (t)
      0: return "alu_mix";
      1: return "decode_jumps";
      2: return "cond_jumps";
      3: return "reg_jumps";
      4: return "back_to_back";
      default: return "reset_mid_program";
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Mismatch %s: expected %0h, actual %0h", what, expected, actual);
      errors++;
    end
  endtask

  task automatic load_program(input int t);
    for (int a = 0; a < 2048; a++) begin
      mem[11'(a)] = random_word(t);
    end
    // address zero always loads a register so every test writes at least once
    mem[0][4:0] = cpu_pkg::OP_LI;
  endtask

  task automatic reset_model();
    for (int i = 0; i < 8; i++) begin
      m_regs[3'(i)] = 16'd0;
    end
    m_z = 1'b0;
    m_n = 1'b0;
    m_pc = 11'd0;
  endtask

  // one instruction in program order, straight from the instruction set rules
  task automatic step_model(output logic wrote, output logic [2:0] wrd,
                            output logic [15:0] wdata);
    cpu_pkg::instr_t   w;
    cpu_pkg::opcode_t  opc;
    logic [15:0]       a;
    logic [15:0]       b;
    logic [15:0]       d;
    logic [15:0]       imm;
    logic [15:0]       res;
    logic [10:0]       jt;
    logic [10:0]       nxt;
    logic              flags;
    logic              link;
    w = mem[m_pc];
    opc = w[4:0];
    a = m_regs[w[10:8]];
    b = m_regs[w[13:11]];
    d = m_regs[w[7:5]];
    imm = {{8{w[15]}}, w[15:8]};
    jt = w[15:5];
    nxt = m_pc + 11'd1;
    case (opc)
      cpu_pkg::OP_ADD: res = a + b;
      cpu_pkg::OP_SUB, cpu_pkg::OP_CMP: res = a - b;
      cpu_pkg::OP_AND: res = a & b;
      cpu_pkg::OP_OR: res = a | b;
      cpu_pkg::OP_ADDI: res = d + imm;
      cpu_pkg::OP_SUBI, cpu_pkg::OP_CMPI: res = d - imm;
      cpu_pkg::OP_LI: res = imm;
      default: res = 16'd0;
    endcase
    flags = opc inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_CMP,
                        cpu_pkg::OP_ADDI, cpu_pkg::OP_SUBI, cpu_pkg::OP_CMPI};
    wrote = opc inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
                        cpu_pkg::OP_ADDI, cpu_pkg::OP_SUBI, cpu_pkg::OP_LI};
    link = (opc == cpu_pkg::OP_CALL) || (opc == cpu_pkg::OP_CALLR);
    // conditions look at the flags left by earlier instructions
    case (opc)
      cpu_pkg::OP_J, cpu_pkg::OP_CALL: nxt = jt;
      cpu_pkg::OP_JZ: if (m_z) nxt = jt;
      cpu_pkg::OP_JN: if (m_n) nxt = jt;
      cpu_pkg::OP_JR, cpu_pkg::OP_CALLR: nxt = a[10:0];
      cpu_pkg::OP_JZR: if (m_z) nxt = a[10:0];
      cpu_pkg::OP_JNR: if (m_n) nxt = a[10:0];
      default: ;
    endcase
    if (flags) begin
      m_z = (res == 16'd0);
      m_n = res[15];
    end
    wrd = link ? 3'd7 : w[7:5];
    wdata = link ? {5'd0, m_pc + 11'd1} : res;
    wrote = wrote || link;
    if (wrote) begin
      m_regs[wrd] = wdata;
    end
    m_pc = nxt;
  endtask

  task automatic run_test(input int t);
    string        name;
    int           errors_before;
    int           writes;
    int           steps;
    logic         found;
    logic [2:0]   exp_rd;
    logic [15:0]  exp_data;
    name = test_name(t);
    errors_before = errors;
    writes = 0;
    // reset lands while the previous program is still running
    @(negedge clk);
    arst_n = 1'b0;
    load_program(t);
    reset_model();
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      imem_data = mem[imem_addr];
    end
    if (wb.valid) begin
      $display("ERROR: %s register write presented while reset was asserted", name);
      errors++;
    end
    check_value({name, ".pc_at_release"}, 32'd0, 32'(imem_addr));
    arst_n = 1'b1;
    for (int c = 0; c < WINDOW; c++) begin
      @(negedge clk);
      if (wb.valid) begin
        writes++;
        if (c == 0) begin
          $display("ERROR: %s register write one cycle after reset release", name);
          errors++;
        end
        // once the streams diverge the rest of this test says nothing new
        if (errors == errors_before) begin
          found = 1'b0;
          steps = 0;
          while (!found && steps < MAX_STEPS) begin
            step_model(found, exp_rd, exp_data);
            steps++;
          end
          if (!found) begin
            $display("ERROR: %s model ran %0d instructions without a register write",
                     name, MAX_STEPS);
            errors++;
          end else begin
            check_value({name, ".rd"}, 32'(exp_rd), 32'(wb.rd));
            check_value({name, ".data"}, 32'(exp_data), 32'(wb.data));
          end
        end
      end
      imem_data = mem[imem_addr];
    end
    if (writes == 0) begin
      $display("ERROR: %s saw no register write at all", name);
      errors++;
    end
    $display("%s: %0d writes checked, %0d errors", name, writes, errors - errors_before);
    total_writes += writes;
  endtask

  initial begin
    clk = 1'b0;
    arst_n = 1'b0;
    imem_data = cpu_pkg::NOP_WORD;
    lfsr = SEED;
    errors = 0;
    total_writes = 0;
    for (int t = 0; t < NTESTS; t++) begin
      run_test(t);
    end
    @(negedge clk);
    errors += int'(dut_i.props_i.assert_fails);
    $display("summary: %0d tests, %0d writes, %0d errors, %0d assertion failures",
             NTESTS, total_writes, errors, dut_i.props_i.assert_fails);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // every test takes a fixed window, so the whole run has a known length
  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/cpu_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_props (
  input  wire                       i_clk,
  input  wire                       i_arst_n,
  input  wire                       i_dc_jump,
  input  wire                       i_ex_jump,
  input  wire [cpu_pkg::PC_W-1:0]   i_ex_target,
  input  wire [cpu_pkg::PC_W-1:0]   i_pc,
  input  wire cpu_pkg::instr_t      i_ir_dc,
  input  wire cpu_pkg::instr_t      i_ir_ex,
  input  wire cpu_pkg::wb_t         i_wb
);

  // number of assertion failures seen since the start of the run
  int unsigned assert_fails = 0;

  // the first fetched word only reaches execute two cycles after release
  wb_idle_after_reset: assert property (@(posedge i_clk)
    (i_arst_n && !$past(i_arst_n, 2)) |-> !i_wb.valid)
    else begin
      assert_fails++;
      $error("register write presented within two cycles of reset release");
    end

  // the word behind a taken execute jump is squashed on its way into execute
  ex_jump_flushes_execute: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_ex_jump |=> (i_ir_ex == cpu_pkg::NOP_WORD))
    else begin
      assert_fails++;
      $error("execute jump did not turn the next execute word into a no-op");
    end

  // j and call replace the word fetched beside them
  dc_jump_flushes_decode: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_dc_jump |=> (i_ir_dc == cpu_pkg::NOP_WORD))
    else begin
      assert_fails++;
      $error("decode jump did not turn the next decode word into a no-op");
    end

  ex_jump_loads_target: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_ex_jump |=> (i_pc == $past(i_ex_target)))
    else begin
      assert_fails++;
      $error("program counter missed the execute jump target");
    end

endmodule

bind cpu_top cpu_props props_i (
  .i_clk       (i_clk),
  .i_arst_n    (i_arst_n),
  .i_dc_jump   (dc_jump_i),
  .i_ex_jump   (ex_jump),
  .i_ex_target (ex_target),
  .i_pc        (o_imem_addr),
  .i_ir_dc     (ir_dc),
  .i_ir_ex     (ir_ex),
  .i_wb        (o_wb)
);

`default_nettype wire

// ==== design/cpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_top (
  input  wire                       i_clk,
  input  wire                       i_arst_n,
  output logic [cpu_pkg::PC_W-1:0]  o_imem_addr,
  input  wire cpu_pkg::instr_t      i_imem_data,
  output cpu_pkg::wb_t              o_wb
);

  cpu_pkg::instr_t            ir_dc;
  cpu_pkg::instr_t            ir_ex;
  logic [cpu_pkg::PC_W-1:0]   pc_dc;
  logic [cpu_pkg::PC_W-1:0]   ex_target;
  logic                       alu_z;
  logic                       alu_n;
  logic                       dc_jump_i;
  logic                       ex_jump_i;
  logic                       ex_jump_r;
  logic                       ex_jump;
  logic [cpu_pkg::REG_W-1:0]  ra;
  logic [cpu_pkg::REG_W-1:0]  rb;
  logic [cpu_pkg::XLEN-1:0]   rf_a;
  logic [cpu_pkg::XLEN-1:0]   rf_b;
  cpu_pkg::dc_ex_t            dc_ex;
  cpu_pkg::wb_t               wb;

  // any taken jump in execute redirects fetch and flushes both younger stages
  assign ex_jump = ex_jump_i | ex_jump_r;

  fetch_unit fetch_i (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_imem_data (i_imem_data),
    .i_dc_jump   (dc_jump_i),
    .i_ex_jump   (ex_jump),
    .i_ex_target (ex_target),
    .o_imem_addr (o_imem_addr),
    .o_ir_dc     (ir_dc),
    .o_pc_dc     (pc_dc)
  );

  detect_jump jump_i (
    .i_ir_dc     (ir_dc),
    .i_ir_ex     (ir_ex),
    .i_alu_z     (alu_z),
    .i_alu_n     (alu_n),
    .o_dc_jump_i (dc_jump_i),
    .o_ex_jump_i (ex_jump_i),
    .o_ex_jump_r (ex_jump_r)
  );

  decode_stage decode_i (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_ir_dc  (ir_dc),
    .i_pc_dc  (pc_dc),
    .i_flush  (ex_jump),
    .i_wb     (wb),
    .o_ra     (ra),
    .o_rb     (rb),
    .i_a      (rf_a),
    .i_b      (rf_b),
    .o_dc_ex  (dc_ex)
  );

  reg_file regs_i (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_ra     (ra),
    .i_rb     (rb),
    .o_a      (rf_a),
    .o_b      (rf_b),
    .i_wb     (wb)
  );

  execute_stage execute_i (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_dc_ex  (dc_ex),
    .o_ir_ex  (ir_ex),
    .o_z      (alu_z),
    .o_n      (alu_n),
    .o_target (ex_target),
    .o_wb     (wb)
  );

  // the write record leaves the core in the same cycle it reaches the registers
  assign o_wb = wb;

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
  input  wire                        i_clk,
  input  wire                        i_arst_n,
  input  wire cpu_pkg::dc_ex_t       i_dc_ex,
  output cpu_pkg::instr_t            o_ir_ex,
  output logic                       o_z,
  output logic                       o_n,
  output logic [cpu_pkg::PC_W-1:0]   o_target,
  output cpu_pkg::wb_t               o_wb
);

  cpu_pkg::instr_t            ir;
  cpu_pkg::opcode_t           opc;
  logic [cpu_pkg::REG_W-1:0]  rd;
  logic [cpu_pkg::XLEN-1:0]   opa;
  logic [cpu_pkg::XLEN-1:0]   opb;
  logic [cpu_pkg::XLEN-1:0]   imm_sx;
  logic [cpu_pkg::XLEN-1:0]   link;
  logic [cpu_pkg::XLEN-1:0]   result;
  logic                       sets_flags;
  logic                       writes_rd;
  logic                       is_call;
  logic                       z_q;
  logic                       n_q;
  cpu_pkg::wb_t               wb;

  assign ir = i_dc_ex.instr;
  assign opa = i_dc_ex.opa;
  assign opb = i_dc_ex.opb;
  assign opc = ir[cpu_pkg::OPC_LSB +: cpu_pkg::OPC_W];
  assign rd = ir[cpu_pkg::RD_LSB +: cpu_pkg::REG_W];

  // 8-bit signed constant from the top byte
  assign imm_sx = {{(cpu_pkg::XLEN - cpu_pkg::IMM_W){ir[cpu_pkg::IMM_LSB + cpu_pkg::IMM_W - 1]}},
                   ir[cpu_pkg::IMM_LSB +: cpu_pkg::IMM_W]};

  // link value is the zero-extended address after the call
  assign link = {{(cpu_pkg::XLEN - cpu_pkg::PC_W){1'b0}}, i_dc_ex.pc_next};

  always_comb begin
    result = '0;
    sets_flags = 1'b0;
    writes_rd = 1'b0;
    case (opc)
      cpu_pkg::OP_ADD: begin
        result = opa + opb;
        sets_flags = 1'b1;
        writes_rd = 1'b1;
      end
      cpu_pkg::OP_SUB: begin
        result = opa - opb;
        sets_flags = 1'b1;
        writes_rd = 1'b1;
      end
      // compares only leave their mark in the flags
      cpu_pkg::OP_CMP: begin
        result = opa - opb;
        sets_flags = 1'b1;
      end
      cpu_pkg::OP_AND: begin
        result = opa & opb;
        writes_rd = 1'b1;
      end
      cpu_pkg::OP_OR: begin
        result = opa | opb;
        writes_rd = 1'b1;
      end
      cpu_pkg::OP_ADDI: begin
        result = opa + imm_sx;
        sets_flags = 1'b1;
        writes_rd = 1'b1;
      end
      cpu_pkg::OP_SUBI: begin
        result = opa - imm_sx;
        sets_flags = 1'b1;
        writes_rd = 1'b1;
      end
      cpu_pkg::OP_CMPI: begin
        result = opa - imm_sx;
        sets_flags = 1'b1;
      end
      cpu_pkg::OP_LI: begin
        result = imm_sx;
        writes_rd = 1'b1;
      end
      default: begin
        // jumps and undefined codes leave the datapath alone
        result = '0;
      end
    endcase
  end

  // the flags seen by a conditional jump come from the instruction before it
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      z_q <= 1'b0;
      n_q <= 1'b0;
    end else if (sets_flags) begin
      z_q <= (result == '0);
      n_q <= result[cpu_pkg::XLEN-1];
    end
  end

  // jz and jn use the word's field, register jumps the low bits of the source
  assign o_target = ir[cpu_pkg::IMM_FORM_BIT] ? ir[cpu_pkg::JT_LSB +: cpu_pkg::PC_W]
                                              : opa[cpu_pkg::PC_W-1:0];

  assign is_call = (opc == cpu_pkg::OP_CALL) || (opc == cpu_pkg::OP_CALLR);

  always_comb begin
    wb.valid = writes_rd || is_call;
    wb.rd = is_call ? cpu_pkg::LINK_REG : rd;
    wb.data = is_call ? link : result;
  end

  assign o_wb = wb;
  assign o_ir_ex = ir;
  assign o_z = z_q;
  assign o_n = n_q;

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  wire                        i_clk,
  input  wire                        i_arst_n,
  input  wire [cpu_pkg::REG_W-1:0]   i_ra,
  input  wire [cpu_pkg::REG_W-1:0]   i_rb,
  output logic [cpu_pkg::XLEN-1:0]   o_a,
  output logic [cpu_pkg::XLEN-1:0]   o_b,
  input  wire cpu_pkg::wb_t          i_wb
);

  logic [cpu_pkg::XLEN-1:0] regs_q [cpu_pkg::NREG];

  // every register starts at zero, r0 included, it is an ordinary register
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < cpu_pkg::NREG; i++) begin
        regs_q[i] <= '0;
      end
    end else if (i_wb.valid) begin
      regs_q[i_wb.rd] <= i_wb.data;
    end
  end

  // reads are combinational, the write of this cycle is bypassed in decode
  assign o_a = regs_q[i_ra];
  assign o_b = regs_q[i_rb];

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
  input  wire                        i_clk,
  input  wire                        i_arst_n,
  input  wire cpu_pkg::instr_t       i_ir_dc,
  input  wire [cpu_pkg::PC_W-1:0]    i_pc_dc,
  input  wire                        i_flush,
  input  wire cpu_pkg::wb_t          i_wb,
  output logic [cpu_pkg::REG_W-1:0]  o_ra,
  output logic [cpu_pkg::REG_W-1:0]  o_rb,
  input  wire [cpu_pkg::XLEN-1:0]    i_a,
  input  wire [cpu_pkg::XLEN-1:0]    i_b,
  output cpu_pkg::dc_ex_t            o_dc_ex
);

  logic                       imm_form;
  logic [cpu_pkg::REG_W-1:0]  ra;
  logic [cpu_pkg::REG_W-1:0]  rb;
  logic [cpu_pkg::XLEN-1:0]   opa;
  logic [cpu_pkg::XLEN-1:0]   opb;
  cpu_pkg::instr_t            instr_q;
  logic [cpu_pkg::PC_W-1:0]   pc_next_q;
  logic [cpu_pkg::XLEN-1:0]   opa_q;
  logic [cpu_pkg::XLEN-1:0]   opb_q;

  // immediate forms read their destination, since bits 15..8 hold the constant
  // j and call also have bit 4 set but never look at their operands
  assign imm_form = i_ir_dc[cpu_pkg::IMM_FORM_BIT];

  assign ra = imm_form ? i_ir_dc[cpu_pkg::RD_LSB +: cpu_pkg::REG_W]
                       : i_ir_dc[cpu_pkg::RS1_LSB +: cpu_pkg::REG_W];
  assign rb = i_ir_dc[cpu_pkg::RS2_LSB +: cpu_pkg::REG_W];

  assign o_ra = ra;
  assign o_rb = rb;

  // the instruction in execute writes at the end of this cycle, so its result
  // is newer than what the register file returns
  assign opa = (i_wb.valid && (i_wb.rd == ra)) ? i_wb.data : i_a;
  assign opb = (i_wb.valid && (i_wb.rd == rb)) ? i_wb.data : i_b;

  // an execute redirect turns the word behind it into a no-op
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      instr_q <= cpu_pkg::NOP_WORD;
    end else if (i_flush) begin
      instr_q <= cpu_pkg::NOP_WORD;
    end else begin
      instr_q <= i_ir_dc;
    end
  end

  // operands and link address only matter next to a live instruction word
  always_ff @(posedge i_clk) begin
    pc_next_q <= i_pc_dc;
    opa_q <= opa;
    opb_q <= opb;
  end

  assign o_dc_ex = '{
    instr:   instr_q,
    pc_next: pc_next_q,
    opa:     opa_q,
    opb:     opb_q
  };

endmodule

`default_nettype wire

// ==== design/detect_jump.sv ====
`timescale 1ns/100ps
`default_nettype none

module detect_jump (
  input  wire cpu_pkg::instr_t  i_ir_dc,
  input  wire cpu_pkg::instr_t  i_ir_ex,
  input  wire                   i_alu_z,
  input  wire                   i_alu_n,
  output logic                  o_dc_jump_i,
  output logic                  o_ex_jump_i,
  output logic                  o_ex_jump_r
);

  cpu_pkg::opcode_t opc_dc;
  cpu_pkg::opcode_t opc_ex;

  assign opc_dc = i_ir_dc[cpu_pkg::OPC_LSB +: cpu_pkg::OPC_W];
  assign opc_ex = i_ir_ex[cpu_pkg::OPC_LSB +: cpu_pkg::OPC_W];

  always_comb begin
    // j and call need nothing but the word, so they leave from decode
    o_dc_jump_i = (opc_dc == cpu_pkg::OP_J) || (opc_dc == cpu_pkg::OP_CALL);

    // jz and jn wait for execute where the flag register holds the previous result
    o_ex_jump_i = ((opc_ex == cpu_pkg::OP_JZ) && i_alu_z) ||
                  ((opc_ex == cpu_pkg::OP_JN) && i_alu_n);

    // register jumps take their target from the forwarded operand in execute
    o_ex_jump_r = (opc_ex == cpu_pkg::OP_JR) || (opc_ex == cpu_pkg::OP_CALLR) ||
                  ((opc_ex == cpu_pkg::OP_JZR) && i_alu_z) ||
                  ((opc_ex == cpu_pkg::OP_JNR) && i_alu_n);
  end

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
  input  wire                       i_clk,
  input  wire                       i_arst_n,
  input  wire cpu_pkg::instr_t      i_imem_data,
  input  wire                       i_dc_jump,
  input  wire                       i_ex_jump,
  input  wire [cpu_pkg::PC_W-1:0]   i_ex_target,
  output logic [cpu_pkg::PC_W-1:0]  o_imem_addr,
  output cpu_pkg::instr_t           o_ir_dc,
  output logic [cpu_pkg::PC_W-1:0]  o_pc_dc
);

  logic [cpu_pkg::PC_W-1:0] pc_q;
  logic [cpu_pkg::PC_W-1:0] pc_d;
  logic [cpu_pkg::PC_W-1:0] pc_inc;
  logic [cpu_pkg::PC_W-1:0] pc_dc_q;
  logic [cpu_pkg::PC_W-1:0] dc_target;
  cpu_pkg::instr_t          ir_dc_q;
  cpu_pkg::instr_t          ir_dc_d;

  // the memory sees the counter directly and answers in the same cycle
  assign o_imem_addr = pc_q;
  assign pc_inc = pc_q + 1'b1;

  // j and call carry their target in the upper 11 bits of the decode word
  assign dc_target = ir_dc_q[cpu_pkg::JT_LSB +: cpu_pkg::PC_W];

  // execute redirects win over decode redirects since the decode word is younger
  // and gets squashed anyway when execute jumps
  always_comb begin
    pc_d = pc_inc;
    ir_dc_d = i_imem_data;
    if (i_ex_jump) begin
      pc_d = i_ex_target;
      ir_dc_d = cpu_pkg::NOP_WORD;
    end else if (i_dc_jump) begin
      // the word fetched alongside a decode jump is on the wrong path
      pc_d = dc_target;
      ir_dc_d = cpu_pkg::NOP_WORD;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc_q <= '0;
      ir_dc_q <= cpu_pkg::NOP_WORD;
    end else begin
      pc_q <= pc_d;
      ir_dc_q <= ir_dc_d;
    end
  end

  // address after the fetched word, used as link value by call and callr
  always_ff @(posedge i_clk) begin
    pc_dc_q <= pc_inc;
  end

  assign o_ir_dc = ir_dc_q;
  assign o_pc_dc = pc_dc_q;

endmodule

`default_nettype wire

// ==== common/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  // datapath width and the program counter that indexes instruction memory
  localparam int XLEN = 16;
  localparam int PC_W = 11;

  // register file geometry, calls always link into the top register
  localparam int NREG = 8;
  localparam int REG_W = 3;
  localparam logic [REG_W-1:0] LINK_REG = 3'd7;

  // field positions inside a 16-bit instruction word
  localparam int OPC_LSB = 0;
  localparam int OPC_W = 5;
  localparam int RD_LSB = 5;
  localparam int RS1_LSB = 8;
  localparam int RS2_LSB = 11;
  localparam int IMM_LSB = 8;
  localparam int IMM_W = 8;
  localparam int JT_LSB = 5;

  // bit 4 of the opcode marks immediate forms and immediate jumps
  localparam int IMM_FORM_BIT = 4;

  typedef logic [OPC_W-1:0] opcode_t;

  // register ALU operations
  localparam opcode_t OP_ADD = 5'b00001;
  localparam opcode_t OP_SUB = 5'b00010;
  localparam opcode_t OP_CMP = 5'b00011;
  localparam opcode_t OP_AND = 5'b00100;
  localparam opcode_t OP_OR = 5'b00101;

  // immediate ALU operations, destination is both source and result
  localparam opcode_t OP_ADDI = 5'b10001;
  localparam opcode_t OP_SUBI = 5'b10010;
  localparam opcode_t OP_CMPI = 5'b10011;
  localparam opcode_t OP_LI = 5'b10100;

  // jumps with an 11-bit absolute target in the word
  localparam opcode_t OP_J = 5'b11000;
  localparam opcode_t OP_CALL = 5'b11100;
  localparam opcode_t OP_JZ = 5'b11001;
  localparam opcode_t OP_JN = 5'b11010;

  // jumps to the low bits of the first source register
  localparam opcode_t OP_JR = 5'b01000;
  localparam opcode_t OP_JZR = 5'b01001;
  localparam opcode_t OP_JNR = 5'b01010;
  localparam opcode_t OP_CALLR = 5'b01100;

  typedef logic [XLEN-1:0] instr_t;

  // opcode zero is not defined, so the all-zero word behaves as a no-op
  localparam instr_t NOP_WORD = 16'h0000;

  // everything execute needs from decode
  typedef struct packed {
    instr_t            instr;
    logic [PC_W-1:0]   pc_next;
    logic [XLEN-1:0]   opa;
    logic [XLEN-1:0]   opb;
  } dc_ex_t;

  // one register write, presented by execute and consumed by the register file
  typedef struct packed {
    logic              valid;
    logic [REG_W-1:0]  rd;
    logic [XLEN-1:0]   data;
  } wb_t;

endpackage

`default_nettype wire
